// ==== board_pkg.sv ====
// Board subsystem shared definitions

package board_pkg;

	// Bus and register widths
	localparam int GPIO_W  = 16; // One pad bank or register word
	localparam int ADDR_W  = 2;  // Four registers in the map
	localparam int LEVEL_W = 4;  // Brightness steps per LED channel

	typedef logic [GPIO_W-1:0]  gpio_word_t;
	typedef logic [ADDR_W-1:0]  reg_addr_t;
	typedef logic [LEVEL_W-1:0] led_level_t;

	// One bus request, carried with req_valid
	typedef struct packed {
		logic       write; // High for a write, low for a read
		reg_addr_t  addr;  // Register index
		gpio_word_t wdata; // Write payload, ignored on reads
	} gpio_req_t;

	// Register map
	localparam reg_addr_t REG_OUT = 2'd0; // Pad output levels
	localparam reg_addr_t REG_OE  = 2'd1; // Pad output enables
	localparam reg_addr_t REG_IN  = 2'd2; // Synchronized pad inputs, read only
	localparam reg_addr_t REG_LED = 2'd3; // Packed RGB brightness levels

	// Field positions inside REG_LED, bits 15:12 read as zero
	localparam int LED_G_LSB = 0;
	localparam int LED_R_LSB = 4;
	localparam int LED_B_LSB = 8;

	// Pins that reach a real pad
	// Bit 0 stays inside as the LED line
	localparam gpio_word_t PAD_MASK = 16'hfffe;

	// Reset generator timing
	localparam int RST_SHIFT = 3;   // Synchronizer depth on the request
	localparam int RST_COUNT = 200; // Released cycles before logic starts
	localparam int RST_CNT_W = $clog2(RST_COUNT + 1);

	// Heartbeat half-period in cycles
	// Scaled down for simulation and kept a multiple of 16 so the PWM lines up
	localparam int HEARTBEAT_DIV = 64;
	localparam int HB_CNT_W      = $clog2(HEARTBEAT_DIV);

endpackage

// ==== fpga_reset.sv ====
// Power-up reset generator

`timescale 1ns/1ps

module fpga_reset (
	input  logic clk,
	input  logic rst,    // Reset request from the board
	output logic rst_sys // Stretched reset for the whole design
);
	import board_pkg::*;

	logic [RST_SHIFT-1:0] sync_q; // Request synchronizer, all ones while held
	logic [RST_CNT_W-1:0] cnt_q;  // Cycles seen since the synchronizer drained
	logic                 hold_q; // Keeps reset asserted through the count

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q <= '1;
			cnt_q  <= '0;
			hold_q <= 1'b1;
		end else begin
			sync_q <= {sync_q[RST_SHIFT-2:0], 1'b0}; // Drain ones out of the top
			// Count only once the released request has crossed the synchronizer
			if (sync_q[RST_SHIFT-1]) begin
				cnt_q <= '0;
			end else if (cnt_q != RST_CNT_W'(RST_COUNT)) begin
				cnt_q <= cnt_q + 1'b1;
			end
			hold_q <= sync_q[RST_SHIFT-1] || (cnt_q != RST_CNT_W'(RST_COUNT));
		end
	end

	// The board request shows up right away, the release comes after the count
	assign rst_sys = rst | hold_q;

endmodule

// ==== blinky.sv ====
// Heartbeat divider

`timescale 1ns/1ps

module blinky (
	input  logic clk,
	input  logic rst,
	output logic blink // Square wave, low out of reset
);
	import board_pkg::*;

	logic [HB_CNT_W-1:0] div_q; // Position inside the current half-period

	always_ff @(posedge clk) begin
		if (rst) begin
			div_q <= '0;
			blink <= 1'b0;
		end else if (div_q == HB_CNT_W'(HEARTBEAT_DIV - 1)) begin
			div_q <= '0;     // Wrap at the end of the half-period
			blink <= ~blink; // and flip the output
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	// With a half-period of HEARTBEAT_DIV cycles the first rising edge
	// lands HEARTBEAT_DIV cycles after reset releases
	// Runs on its own with no bus access, so it shows the clock is alive

endmodule

// ==== gpio_regs.sv ====
// GPIO register block on the request/response bus

`timescale 1ns/1ps

module gpio_regs (
	input  logic                  clk,
	input  logic                  rst,
	input  board_pkg::gpio_req_t  req,
	input  logic                  req_valid,
	output logic                  req_ready,
	output logic                  rsp_valid,
	output board_pkg::gpio_word_t rsp_data,
	input  logic                  rsp_ready,
	input  board_pkg::gpio_word_t pad_in,
	output board_pkg::gpio_word_t out_word,
	output board_pkg::gpio_word_t oe_word,
	output board_pkg::led_level_t level_g,
	output board_pkg::led_level_t level_r,
	output board_pkg::led_level_t level_b
);
	import board_pkg::*;

	gpio_word_t in_meta_q; // First synchronizer stage, may go metastable
	gpio_word_t in_sync_q; // Settled copy of the pad inputs

	gpio_word_t out_nxt;
	gpio_word_t oe_nxt;
	led_level_t g_nxt;
	led_level_t r_nxt;
	led_level_t b_nxt;
	gpio_word_t rd_word; // Register value after the current operation
	logic       accept;

	// Only one transfer is in flight, so a pending response blocks new requests
	assign req_ready = !rsp_valid && !rst;
	assign accept    = req_valid && req_ready;

	always_comb begin
		out_nxt = out_word;
		oe_nxt  = oe_word;
		g_nxt   = level_g;
		r_nxt   = level_r;
		b_nxt   = level_b;
		if (accept && req.write) begin
			unique case (req.addr)
				REG_OUT: out_nxt = req.wdata;
				REG_OE:  oe_nxt  = req.wdata;
				REG_IN:  ; // Read only, the write is dropped
				REG_LED: begin
					g_nxt = req.wdata[LED_G_LSB +: LEVEL_W];
					r_nxt = req.wdata[LED_R_LSB +: LEVEL_W];
					b_nxt = req.wdata[LED_B_LSB +: LEVEL_W];
				end
			endcase
		end

		// Reads and writes both answer with the post-operation value
		rd_word = '0; // Unused LED bits stay zero
		unique case (req.addr)
			REG_OUT: rd_word = out_nxt;
			REG_OE:  rd_word = oe_nxt;
			REG_IN:  rd_word = in_sync_q;
			REG_LED: begin
				rd_word[LED_G_LSB +: LEVEL_W] = g_nxt;
				rd_word[LED_R_LSB +: LEVEL_W] = r_nxt;
				rd_word[LED_B_LSB +: LEVEL_W] = b_nxt;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_word  <= '0;
			oe_word   <= '0;
			level_g   <= '0;
			level_r   <= '0;
			level_b   <= '0;
			in_meta_q <= '0;
			in_sync_q <= '0;
			rsp_valid <= 1'b0;
		end else begin
			out_word  <= out_nxt; // Writes land on the pins with the response
			oe_word   <= oe_nxt;
			level_g   <= g_nxt;
			level_r   <= r_nxt;
			level_b   <= b_nxt;
			in_meta_q <= pad_in;
			in_sync_q <= in_meta_q;
			if (accept) begin
				rsp_valid <= 1'b1;
			end else if (rsp_ready) begin
				rsp_valid <= 1'b0; // Response taken by the master
			end
		end
	end

	// Holding register, only loaded when a request is taken
	always_ff @(posedge clk) begin
		if (accept) begin
			rsp_data <= rd_word;
		end
	end

endmodule

// ==== led_pwm.sv ====
// RGB LED brightness PWM

`timescale 1ns/1ps

module led_pwm (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  gpio_led,  // Green source from the GPIO block
	input  logic                  heartbeat, // Red source from the divider
	input  board_pkg::led_level_t level_g,
	input  board_pkg::led_level_t level_r,
	input  board_pkg::led_level_t level_b,
	output logic                  led_g,
	output logic                  led_r,
	output logic                  led_b
);
	import board_pkg::*;

	led_level_t pwm_q; // Shared free-running phase, one period is 16 cycles
	logic       on_g;
	logic       on_r;
	logic       on_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			pwm_q <= '0;
		end else begin
			pwm_q <= pwm_q + 1'b1; // Wraps on its own at 16
		end
	end

	// A channel is lit for level cycles out of every 16
	// Level zero keeps it dark, there is no full-on step
	assign on_g = pwm_q < level_g;
	assign on_r = pwm_q < level_r;
	assign on_b = pwm_q < level_b;

	// Registered so the pins see no compare glitches
	always_ff @(posedge clk) begin
		if (rst) begin
			led_g <= 1'b0;
			led_r <= 1'b0;
			led_b <= 1'b0;
		end else begin
			led_g <= gpio_led & on_g;
			led_r <= heartbeat & on_r; // Heartbeat dimmed by the red level
			led_b <= on_b;             // Blue has no source of its own
		end
	end

	// The heartbeat half-period is a whole number of PWM periods,
	// so red brightness does not drift with the phase between the two

endmodule

// ==== board_top.sv ====
// Board subsystem top level

`timescale 1ns/1ps

module board_top (
	input  logic                  clk,
	input  logic                  rst,
	input  board_pkg::gpio_req_t  req,
	input  logic                  req_valid,
	output logic                  req_ready,
	output logic                  rsp_valid,
	output board_pkg::gpio_word_t rsp_data,
	input  logic                  rsp_ready,
	input  board_pkg::gpio_word_t pad_in,
	output board_pkg::gpio_word_t pad_out,
	output board_pkg::gpio_word_t pad_oe,
	output logic                  led_r,
	output logic                  led_g,
	output logic                  led_b,
	output logic                  led_mirror // Raw LED line brought out for probing
);
	import board_pkg::*;

	logic       rst_sys;   // Stretched reset for everything below
	logic       heartbeat;
	logic       gpio_led;
	gpio_word_t out_word;
	gpio_word_t oe_word;
	led_level_t level_g;
	led_level_t level_r;
	led_level_t level_b;

	fpga_reset i_reset (
		.clk     (clk),
		.rst     (rst),
		.rst_sys (rst_sys)
	);

	gpio_regs i_gpio (
		.clk       (clk),
		.rst       (rst_sys),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready),
		.pad_in    (pad_in),
		.out_word  (out_word),
		.oe_word   (oe_word),
		.level_g   (level_g),
		.level_r   (level_r),
		.level_b   (level_b)
	);

	blinky i_blinky (
		.clk   (clk),
		.rst   (rst_sys),
		.blink (heartbeat)
	);

	led_pwm i_led (
		.clk       (clk),
		.rst       (rst_sys),
		.gpio_led  (gpio_led),
		.heartbeat (heartbeat),
		.level_g   (level_g),
		.level_r   (level_r),
		.level_b   (level_b),
		.led_g     (led_g),
		.led_r     (led_r),
		.led_b     (led_b)
	);

	assign gpio_led   = out_word[0]; // Pin 0 never reaches a pad
	assign led_mirror = gpio_led;
	assign pad_out    = out_word & PAD_MASK;
	assign pad_oe     = oe_word & PAD_MASK; // Internal pins never drive

endmodule

// ==== board_tb.sv ====
// Board subsystem testbench

`timescale 1ns/1ps

module board_tb;
	import board_pkg::*;

	localparam int WAIT_LIMIT = 64;                          // Cycles one handshake may take
	localparam int RST_LIMIT  = RST_SHIFT + RST_COUNT + 50; // Upper bound on the reset stretch

	logic       clk;
	logic       rst;
	gpio_req_t  req;
	logic       req_valid;
	logic       req_ready;
	logic       rsp_valid;
	gpio_word_t rsp_data;
	logic       rsp_ready;
	gpio_word_t pad_in;
	gpio_word_t pad_out;
	gpio_word_t pad_oe;
	logic       led_r;
	logic       led_g;
	logic       led_b;
	logic       led_mirror;

	logic [15:0] lfsr;      // Back-pressure pattern source
	gpio_word_t  model_out; // Register contents as the bus writes define them
	gpio_word_t  model_oe;
	gpio_word_t  model_led;
	int          checks_run;
	int          error_count;
	int          timeout_count;
	logic        aborted;   // Set once a handshake stalls, ends the vector loop

	board_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.rsp_valid  (rsp_valid),
		.rsp_data   (rsp_data),
		.rsp_ready  (rsp_ready),
		.pad_in     (pad_in),
		.pad_out    (pad_out),
		.pad_oe     (pad_oe),
		.led_r      (led_r),
		.led_g      (led_g),
		.led_b      (led_b),
		.led_mirror (led_mirror)
	);

	always #2 clk = ~clk; // 4 ns period

	// Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_random_bit();
		logic lsb;
		lsb  = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb) begin
			lfsr = lfsr ^ 16'hb400;
		end
		return lsb;
	endfunction

	// Inputs change half a nanosecond past the edge, outputs are settled by then
	task automatic step_clock();
		@(posedge clk);
		#0.5;
	endtask

	task automatic compare_word(input string name, input gpio_word_t expected,
			input gpio_word_t actual);
		checks_run++;
		assert (actual === expected) else begin
			error_count++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic compare_int(input string name, input int expected, input int actual);
		checks_run++;
		assert (actual == expected) else begin
			error_count++;
			$display("mismatch %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks_run++;
		assert (cond) else begin
			error_count++;
			$display("error: %s", what);
		end
	endtask

	task automatic flag_timeout(input logic finished, input string what);
		checks_run++;
		assert (finished) else begin
			error_count++;
			timeout_count++;
			aborted = 1'b1; // Nothing after a stalled bus can be trusted
			$display("timeout waiting for %s", what);
		end
	endtask

	// Hold the request until req_ready is seen, the transfer is on the following edge
	task automatic send_request(input gpio_req_t r, output logic accepted);
		int   n;
		logic ready_seen;
		n          = 0;
		ready_seen = 1'b0;
		req        = r;
		req_valid  = 1'b1;
		while (!ready_seen && n < WAIT_LIMIT) begin
			ready_seen = req_ready;
			step_clock();
			n++;
		end
		req_valid = 1'b0;
		req       = '0;
		flag_timeout(ready_seen, "req_ready");
		accepted = ready_seen;
	endtask

	// Take one response under random rsp_ready and watch it hold while stalled
	task automatic take_response(input string name, input gpio_word_t expected);
		int         n;
		logic       done;
		logic       lost;
		logic       held;
		gpio_word_t first_data;
		n          = 0;
		done       = 1'b0;
		lost       = 1'b0;
		held       = 1'b0;
		first_data = '0;
		expect_true(rsp_valid, {name, ": no response on the cycle after the request"});
		while (!done && !lost && n < WAIT_LIMIT) begin
			rsp_ready = next_random_bit();
			if (!rsp_valid) begin
				lost = 1'b1; // Dropped before the master took it
			end else begin
				if (held) begin
					compare_word({name, " held rsp_data"}, first_data, rsp_data);
				end else begin
					first_data = rsp_data;
					held       = 1'b1;
				end
				expect_true(!req_ready, {name, ": req_ready high with a response pending"});
				if (rsp_ready) begin
					compare_word(name, expected, rsp_data);
					done = 1'b1;
				end
			end
			step_clock();
			n++;
		end
		rsp_ready = 1'b0;
		expect_true(!lost, {name, ": response withdrawn before it was taken"});
		flag_timeout(done || lost, {name, " response"});
		if (done) begin
			expect_true(!rsp_valid, {name, ": response repeated after it was taken"});
		end
	endtask

	// Count LED on-cycles, green and blue per 16-cycle PWM period, red per heartbeat period
	task automatic run_led_window(input string name);
		int exp_g;
		int exp_b;
		int exp_r;
		int g_cnt;
		int b_cnt;
		int r_cnt;
		int i;
		exp_g = model_out[0] ? int'(model_led[LED_G_LSB +: LEVEL_W]) : 0;
		exp_b = int'(model_led[LED_B_LSB +: LEVEL_W]);
		exp_r = HEARTBEAT_DIV * int'(model_led[LED_R_LSB +: LEVEL_W]) / 16; // High half only
		g_cnt = 0;
		b_cnt = 0;
		r_cnt = 0;
		for (i = 0; i < 2 * HEARTBEAT_DIV; i++) begin
			step_clock();
			g_cnt += int'(led_g);
			b_cnt += int'(led_b);
			r_cnt += int'(led_r);
			compare_int({name, " led_mirror"}, int'(model_out[0]), int'(led_mirror));
			if (i % 16 == 15) begin
				compare_int($sformatf("%s green period %0d", name, i / 16), exp_g, g_cnt);
				compare_int($sformatf("%s blue period %0d", name, i / 16), exp_b, b_cnt);
				g_cnt = 0;
				b_cnt = 0;
			end
		end
		compare_int({name, " red window"}, exp_r, r_cnt);
	endtask

	// One vector: set the pads, let the synchronizer settle, then run the operation
	task automatic apply_vector(input string name, input int op, input reg_addr_t addr,
			input gpio_word_t wdata, input gpio_word_t pad, input gpio_word_t expected);
		gpio_req_t r;
		logic      accepted;
		pad_in = pad;
		repeat (3) step_clock();
		if (op == 2) begin
			run_led_window(name);
		end else begin
			r.write = (op == 1);
			r.addr  = addr;
			r.wdata = wdata;
			send_request(r, accepted);
			if (accepted) begin
				if (r.write) begin
					case (addr)
						REG_OUT: model_out = wdata;
						REG_OE:  model_oe  = wdata;
						REG_LED: model_led = wdata & 16'h0fff; // Top nibble has no storage
						default: ;                           // IN takes no writes
					endcase
				end
				take_response(name, expected);
				compare_word({name, " pad_out"}, model_out & PAD_MASK, pad_out);
				compare_word({name, " pad_oe"}, model_oe & PAD_MASK, pad_oe);
				compare_int({name, " led_mirror"}, int'(model_out[0]), int'(led_mirror));
			end
		end
	endtask

	initial begin
		int         fd;
		int         code;
		int         fields;
		int         line_no;
		int         op;
		int         cycles;
		string      line;
		string      name;
		reg_addr_t  addr;
		gpio_word_t wdata;
		gpio_word_t pad;
		gpio_word_t expected;

		clk           = 1'b0;
		rst           = 1'b1;
		req           = '0;
		req_valid     = 1'b0;
		rsp_ready     = 1'b0;
		pad_in        = '0;
		lfsr          = 16'd33310;
		model_out     = '0;
		model_oe      = '0;
		model_led     = '0;
		checks_run    = 0;
		error_count   = 0;
		timeout_count = 0;
		aborted       = 1'b0;

		repeat (4) begin
			step_clock();
			expect_true(!req_ready, "req_ready high while the board reset is held");
		end
		rst = 1'b0;
		step_clock(); // First edge that samples the release
		cycles = 0;
		while (!req_ready && cycles < RST_LIMIT) begin
			compare_word("reset pad_oe", '0, pad_oe);
			compare_word("reset pad_out", '0, pad_out);
			compare_int("reset rsp_valid", 0, int'(rsp_valid));
			compare_int("reset leds", 0, int'(led_r) + int'(led_g) + int'(led_b));
			step_clock();
			cycles++;
		end
		flag_timeout(req_ready, "req_ready after reset");
		compare_int("reset stretch", RST_SHIFT + RST_COUNT, cycles);

		fd = $fopen("board_testdata.txt", "r");
		expect_true(fd != 0, "could not open board_testdata.txt");
		line_no = 0;
		while (fd != 0 && !aborted && !$feof(fd)) begin
			code = $fgets(line, fd);
			line_no++;
			if (code > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
				fields = $sscanf(line, "%d %h %h %h %h", op, addr, wdata, pad, expected);
				name   = $sformatf("line %0d op %0d addr %0d", line_no, op, addr);
				expect_true(fields == 5, $sformatf("line %0d of the vector file is malformed",
					line_no));
				if (fields == 5) begin
					apply_vector(name, op, addr, wdata, pad, expected);
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("checks %0d errors %0d timeouts %0d", checks_run, error_count, timeout_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== board_testdata.txt ====
# op addr wdata pad_in expected, all but op in hex
# op 0 reads, op 1 writes, op 2 counts LED on-cycles over two heartbeat halves
0 0 0000 0000 0000
0 1 0000 0000 0000
0 3 0000 0000 0000
0 2 0000 a5c3 a5c3
1 0 1235 a5c3 1235
1 1 ff0f a5c3 ff0f
0 0 0000 a5c3 1235
0 1 0000 a5c3 ff0f
1 2 dead a5c3 a5c3
0 2 0000 a5c3 a5c3
0 2 0000 0f0f 0f0f
1 3 fa95 0f0f 0a95
0 3 0000 0f0f 0a95
2 0 0000 0f0f 0000
1 0 fffe 3c3c fffe
2 0 0000 3c3c 0000
1 3 0f0c 3c3c 0f0c
1 0 0001 3c3c 0001
2 0 0000 3c3c 0000
1 3 00f0 3c3c 00f0
2 0 0000 3c3c 0000
0 2 0000 8001 8001
1 1 0000 8001 0000
0 1 0000 8001 0000
1 0 0000 8001 0000
0 0 0000 8001 0000
0 3 0000 8001 00f0
2 0 0000 8001 0000

// ==== src.f ====
board_pkg.sv
fpga_reset.sv
blinky.sv
gpio_regs.sv
led_pwm.sv
board_top.sv
board_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = board_tb
FILELIST = src.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
